//--- mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// on-chip memory size in bytes.
`define MEM_BYTES 1024

// bus address width.
`define MEM_ADDR_W 32

// cycles from address acceptance to response valid.
`define MEM_LATENCY 2

`endif

//--- mem_pkg.sv
package mem_pkg;

  // access width of a load, store or fetch.
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  // response code on the read data and write response channels.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } bus_resp_e;

  // strobe pattern for lane zero, indexed by access size.
  localparam logic [3:0] wstrb_lut [0:3] = '{
    4'b0001,  // byte.
    4'b0011,  // half.
    4'b1111,  // word.
    4'b0000   // unused code.
  };

endpackage

//--- bus_if.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

interface bus_if;
  import mem_pkg::*;

  logic [`MEM_ADDR_W-1:0] araddr;
  access_size_e           arsize;
  logic                   arvalid;
  logic                   arready;

  logic [31:0]            rdata;
  bus_resp_e              rresp;
  logic                   rvalid;
  logic                   rready;

  logic [`MEM_ADDR_W-1:0] awaddr;
  access_size_e           awsize;
  logic                   awvalid;
  logic                   awready;

  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   wvalid;
  logic                   wready;

  bus_resp_e              bresp;
  logic                   bvalid;
  logic                   bready;

  modport master (
    output araddr, arsize, arvalid, rready,
    output awaddr, awsize, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arsize, arvalid, rready,
    input  awaddr, awsize, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport monitor (
    input araddr, arsize, arvalid, arready, rdata, rresp, rvalid, rready,
    input awaddr, awsize, awvalid, awready, wdata, wstrb, wvalid, wready,
    input bresp, bvalid, bready
  );

endinterface

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetch_valid,
  output logic        fetch_ready,
  input  logic [31:0] fetch_pc,
  output logic        fetch_rsp_valid,
  input  logic        fetch_rsp_ready,
  output logic [31:0] fetch_insn,
  output logic        fetch_fault,
  bus_if.master       bus
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_respond
  } fetch_state_e;

  fetch_state_e state_q;
  logic         arvalid_q;
  logic [31:0]  pc_q;
  logic         accept;
  logic         rd_done;

  assign accept  = fetch_valid & fetch_ready;
  assign rd_done = bus.rvalid & bus.rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= st_idle;
      arvalid_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q   <= st_busy;
            arvalid_q <= 1'b1;
          end
        end
        st_busy: begin
          if (arvalid_q && bus.arready) begin
            arvalid_q <= 1'b0;
          end
          if (rd_done) begin
            state_q <= st_respond;
          end
        end
        default: begin
          if (fetch_rsp_ready) begin
            state_q <= st_idle;  // result taken.
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pc_q <= {fetch_pc[31:2], 2'b00};
    end
    if (rd_done) begin
      fetch_insn  <= bus.rdata;
      fetch_fault <= (bus.rresp != resp_okay);
    end
  end

  assign fetch_ready     = (state_q == st_idle);
  assign fetch_rsp_valid = (state_q == st_respond);

  assign bus.araddr  = pc_q;
  assign bus.arsize  = size_word;
  assign bus.arvalid = arvalid_q;
  assign bus.rready  = (state_q == st_busy);

  // read-only master.
  assign bus.awaddr  = '0;
  assign bus.awsize  = size_word;
  assign bus.awvalid = 1'b0;
  assign bus.wdata   = '0;
  assign bus.wstrb   = '0;
  assign bus.wvalid  = 1'b0;
  assign bus.bready  = 1'b0;

endmodule

//--- data_access_unit.sv
`timescale 1ns/1ps

module data_access_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 data_valid,
  output logic                 data_ready,
  input  logic [31:0]          data_addr,
  input  mem_pkg::access_size_e data_size,
  input  logic                 data_sext,
  input  logic                 data_write,
  input  logic [31:0]          data_wdata,
  output logic                 data_rsp_valid,
  input  logic                 data_rsp_ready,
  output logic [31:0]          data_rdata,
  output logic                 data_fault,
  bus_if.master                bus
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_respond
  } data_state_e;

  data_state_e  state_q;
  logic         arvalid_q;
  logic         awvalid_q;
  logic         wvalid_q;
  logic [31:0]  addr_q;
  access_size_e size_q;
  logic         sext_q;
  logic [31:0]  wdata_q;
  logic [3:0]   wstrb_q;
  logic         accept;
  logic         rd_done;
  logic         wr_done;

  // shift the addressed lane down, then extend to 32 bits.
  function automatic logic [31:0] align_load(input logic [31:0] rdata,
                                             input logic [1:0] offset,
                                             input logic sext,
                                             input access_size_e size);
    logic [31:0] tmp;
    tmp = rdata >> {offset, 3'b000};
    case (size)
      size_byte: align_load = sext ? {{24{tmp[7]}}, tmp[7:0]} : {24'b0, tmp[7:0]};
      size_half: align_load = sext ? {{16{tmp[15]}}, tmp[15:0]} : {16'b0, tmp[15:0]};
      default:   align_load = tmp;  // word ignores sext.
    endcase
  endfunction

  assign accept  = data_valid & data_ready;
  assign rd_done = bus.rvalid & bus.rready;
  assign wr_done = bus.bvalid & bus.bready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= st_idle;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q   <= st_busy;
            arvalid_q <= ~data_write;
            awvalid_q <= data_write;  // address and data go out together.
            wvalid_q  <= data_write;
          end
        end
        st_busy: begin
          if (arvalid_q && bus.arready) begin
            arvalid_q <= 1'b0;
          end
          if (awvalid_q && bus.awready) begin
            awvalid_q <= 1'b0;
          end
          if (wvalid_q && bus.wready) begin
            wvalid_q <= 1'b0;
          end
          if (rd_done || wr_done) begin
            state_q <= st_respond;
          end
        end
        default: begin
          if (data_rsp_ready) begin
            state_q <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q  <= data_addr;
      size_q  <= data_size;
      sext_q  <= data_sext;
      wdata_q <= data_wdata << {data_addr[1:0], 3'b000};
      wstrb_q <= wstrb_lut[data_size] << data_addr[1:0];
    end
    if (rd_done) begin
      data_rdata <= align_load(bus.rdata, addr_q[1:0], sext_q, size_q);
      data_fault <= (bus.rresp != resp_okay);
    end else if (wr_done) begin
      data_rdata <= '0;  // stores return no data.
      data_fault <= (bus.bresp != resp_okay);
    end
  end

  assign data_ready     = (state_q == st_idle);
  assign data_rsp_valid = (state_q == st_respond);

  assign bus.araddr  = addr_q;
  assign bus.arsize  = size_q;
  assign bus.arvalid = arvalid_q;
  assign bus.awaddr  = addr_q;
  assign bus.awsize  = size_q;
  assign bus.awvalid = awvalid_q;
  assign bus.wdata   = wdata_q;
  assign bus.wstrb   = wstrb_q;
  assign bus.wvalid  = wvalid_q;
  assign bus.rready  = (state_q == st_busy);
  assign bus.bready  = (state_q == st_busy);

endmodule

//--- bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input logic  clock,
  input logic  reset,
  bus_if.slave  fetch_bus,
  bus_if.slave  data_bus,
  bus_if.master mem_bus
);

  logic busy_q;
  logic owner_q;  // 1 is the data master.
  logic last_q;   // winner of the last grant.
  logic fetch_req;
  logic data_req;
  logic sel;
  logic rsp_done;

  assign fetch_req = fetch_bus.arvalid | (fetch_bus.awvalid & fetch_bus.wvalid);
  assign data_req  = data_bus.arvalid | (data_bus.awvalid & data_bus.wvalid);
  assign rsp_done  = (mem_bus.rvalid & mem_bus.rready) | (mem_bus.bvalid & mem_bus.bready);

  always_comb begin
    if (busy_q) begin
      sel = owner_q;
    end else if (fetch_req && data_req) begin
      sel = ~last_q;  // loser of the last round goes first.
    end else begin
      sel = data_req;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      last_q  <= 1'b1;  // fetch wins the first tie.
    end else if (!busy_q && (fetch_req || data_req)) begin
      busy_q  <= 1'b1;
      owner_q <= sel;
      last_q  <= sel;
    end else if (busy_q && rsp_done) begin
      busy_q <= 1'b0;
    end
  end

  assign mem_bus.araddr  = sel ? data_bus.araddr  : fetch_bus.araddr;
  assign mem_bus.arsize  = sel ? data_bus.arsize  : fetch_bus.arsize;
  assign mem_bus.arvalid = sel ? data_bus.arvalid : fetch_bus.arvalid;
  assign mem_bus.rready  = sel ? data_bus.rready  : fetch_bus.rready;
  assign mem_bus.awaddr  = sel ? data_bus.awaddr  : fetch_bus.awaddr;
  assign mem_bus.awsize  = sel ? data_bus.awsize  : fetch_bus.awsize;
  assign mem_bus.awvalid = sel ? data_bus.awvalid : fetch_bus.awvalid;
  assign mem_bus.wdata   = sel ? data_bus.wdata   : fetch_bus.wdata;
  assign mem_bus.wstrb   = sel ? data_bus.wstrb   : fetch_bus.wstrb;
  assign mem_bus.wvalid  = sel ? data_bus.wvalid  : fetch_bus.wvalid;
  assign mem_bus.bready  = sel ? data_bus.bready  : fetch_bus.bready;

  // handshakes only reach the selected master.
  assign fetch_bus.arready = mem_bus.arready & ~sel;
  assign fetch_bus.awready = mem_bus.awready & ~sel;
  assign fetch_bus.wready  = mem_bus.wready  & ~sel;
  assign fetch_bus.rvalid  = mem_bus.rvalid  & ~sel;
  assign fetch_bus.bvalid  = mem_bus.bvalid  & ~sel;
  assign data_bus.arready  = mem_bus.arready & sel;
  assign data_bus.awready  = mem_bus.awready & sel;
  assign data_bus.wready   = mem_bus.wready  & sel;
  assign data_bus.rvalid   = mem_bus.rvalid  & sel;
  assign data_bus.bvalid   = mem_bus.bvalid  & sel;

  // payloads are shared.
  assign fetch_bus.rdata = mem_bus.rdata;
  assign fetch_bus.rresp = mem_bus.rresp;
  assign fetch_bus.bresp = mem_bus.bresp;
  assign data_bus.rdata  = mem_bus.rdata;
  assign data_bus.rresp  = mem_bus.rresp;
  assign data_bus.bresp  = mem_bus.bresp;

endmodule

//--- sram_slave.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram_slave (
  input logic  clock,
  input logic  reset,
  bus_if.slave bus
);
  import mem_pkg::*;

  localparam int idx_w = $clog2(`MEM_BYTES);
  localparam int cnt_w = $clog2(`MEM_LATENCY + 1);

  logic [7:0]       mem_q [0:`MEM_BYTES-1];
  logic             busy_q;
  logic             pend_write_q;
  logic             rsp_valid_q;
  logic [cnt_w-1:0] cnt_q;
  bus_resp_e        resp_q;
  logic [31:0]      rdata_q;
  logic             rd_accept;
  logic             wr_accept;
  logic             rsp_done;
  logic             rd_in_range;
  logic             wr_in_range;
  logic [idx_w-3:0] rd_word;
  logic [idx_w-3:0] wr_word;
  logic [3:0]       wr_mask;
  logic [31:0]      rd_data;

  assign bus.arready = ~busy_q;
  assign bus.awready = ~busy_q & ~bus.arvalid & bus.awvalid & bus.wvalid;
  assign bus.wready  = bus.awready;

  assign rd_accept   = bus.arvalid & bus.arready;
  assign wr_accept   = bus.awvalid & bus.awready;
  assign rsp_done    = (bus.rvalid & bus.rready) | (bus.bvalid & bus.bready);
  assign rd_in_range = (bus.araddr < `MEM_BYTES);
  assign wr_in_range = (bus.awaddr < `MEM_BYTES);
  assign rd_word     = bus.araddr[idx_w-1:2];
  assign wr_word     = bus.awaddr[idx_w-1:2];
  assign wr_mask     = bus.wstrb & (wstrb_lut[bus.awsize] << bus.awaddr[1:0]);
  assign rd_data     = {mem_q[{rd_word, 2'd3}], mem_q[{rd_word, 2'd2}],
                        mem_q[{rd_word, 2'd1}], mem_q[{rd_word, 2'd0}]};

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `MEM_BYTES; i++) begin
        mem_q[i] <= 8'h00;
      end
    end else if (wr_accept && wr_in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_mask[i]) begin
          mem_q[{wr_word, 2'(i)}] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q       <= 1'b0;
      pend_write_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
      cnt_q        <= '0;
    end else if (rd_accept || wr_accept) begin
      busy_q       <= 1'b1;
      pend_write_q <= wr_accept;
      cnt_q        <= cnt_w'(1);
    end else if (busy_q && !rsp_valid_q) begin
      if (cnt_q == cnt_w'(`MEM_LATENCY - 1)) begin
        rsp_valid_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (rsp_done) begin
      busy_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_accept) begin
      rdata_q <= rd_in_range ? rd_data : '0;  // out of range reads zero.
      resp_q  <= rd_in_range ? resp_okay : resp_slverr;
    end else if (wr_accept) begin
      resp_q <= wr_in_range ? resp_okay : resp_slverr;
    end
  end

  assign bus.rdata  = rdata_q;
  assign bus.rresp  = resp_q;
  assign bus.rvalid = rsp_valid_q & ~pend_write_q;
  assign bus.bresp  = resp_q;
  assign bus.bvalid = rsp_valid_q & pend_write_q;

endmodule

//--- mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fetch_valid,
  output logic                  fetch_ready,
  input  logic [31:0]           fetch_pc,
  output logic                  fetch_rsp_valid,
  input  logic                  fetch_rsp_ready,
  output logic [31:0]           fetch_insn,
  output logic                  fetch_fault,
  input  logic                  data_valid,
  output logic                  data_ready,
  input  logic [31:0]           data_addr,
  input  mem_pkg::access_size_e data_size,
  input  logic                  data_sext,
  input  logic                  data_write,
  input  logic [31:0]           data_wdata,
  output logic                  data_rsp_valid,
  input  logic                  data_rsp_ready,
  output logic [31:0]           data_rdata,
  output logic                  data_fault
);

  bus_if fetch_bus ();
  bus_if data_bus ();
  bus_if mem_bus ();

  fetch_unit fetch0 (
    .clock           (clock),
    .reset           (reset),
    .fetch_valid     (fetch_valid),
    .fetch_ready     (fetch_ready),
    .fetch_pc        (fetch_pc),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp_ready (fetch_rsp_ready),
    .fetch_insn      (fetch_insn),
    .fetch_fault     (fetch_fault),
    .bus             (fetch_bus)
  );

  data_access_unit data0 (
    .clock          (clock),
    .reset          (reset),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .data_addr      (data_addr),
    .data_size      (data_size),
    .data_sext      (data_sext),
    .data_write     (data_write),
    .data_wdata     (data_wdata),
    .data_rsp_valid (data_rsp_valid),
    .data_rsp_ready (data_rsp_ready),
    .data_rdata     (data_rdata),
    .data_fault     (data_fault),
    .bus            (data_bus)
  );

  bus_arbiter arb0 (
    .clock     (clock),
    .reset     (reset),
    .fetch_bus (fetch_bus),
    .data_bus  (data_bus),
    .mem_bus   (mem_bus)
  );

  sram_slave mem0 (
    .clock (clock),
    .reset (reset),
    .bus   (mem_bus)
  );

endmodule

//--- mem_checker.sv
`timescale 1ns/1ps

module mem_checker (
  input logic        clock,
  input logic        reset,
  input logic        fetch_ready,
  input logic        fetch_rsp_valid,
  input logic        fetch_rsp_ready,
  input logic [31:0] fetch_insn,
  input logic        fetch_fault,
  input logic        data_ready,
  input logic        data_rsp_valid,
  input logic        data_rsp_ready,
  input logic [31:0] data_rdata,
  input logic        data_fault
);

  int          mismatch_count = 0;
  int          other_count = 0;
  logic [31:0] fetch_exp_data [$];
  logic        fetch_exp_fault [$];
  string       fetch_case [$];
  logic [31:0] data_exp_data [$];
  logic        data_exp_fault [$];
  string       data_case [$];
  logic        reset_q;

  task automatic load_expected();
    int          fd;
    string       line;
    string       port_s;
    string       op_s;
    logic [31:0] addr;
    int          size;
    int          sext;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    int          exp_fault;
    fd = $fopen("mem_cases.txt", "r");
    if (fd == 0) begin
      $display("Checker could not open mem_cases.txt");
      other_count++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[line.len()-1] == 8'h0a) begin
        line = line.substr(0, line.len() - 2);  // drop the newline.
      end
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%s %s %h %d %d %h %h %d", port_s, op_s, addr, size, sext,
                  wdata, exp_data, exp_fault) == 8) begin
        if (port_s == "f") begin
          fetch_exp_data.push_back(exp_data);
          fetch_exp_fault.push_back(exp_fault != 0);
          fetch_case.push_back(line);
        end else begin
          data_exp_data.push_back(exp_data);
          data_exp_fault.push_back(exp_fault != 0);
          data_case.push_back(line);
        end
      end
    end
    $fclose(fd);
  endtask

  function automatic int count_leftovers();
    int left;
    left = fetch_case.size() + data_case.size();
    if (left != 0) begin
      $display("%0d fetch and %0d data cases never got a response",
               fetch_case.size(), data_case.size());
    end
    return left;
  endfunction

  task automatic compare(input string port, input logic [31:0] exp_data,
                         input logic exp_fault, input string line,
                         input logic [31:0] got_data, input logic got_fault);
    if (got_data !== exp_data || got_fault !== exp_fault) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s port got %h/%b, want %h/%b for case '%s'",
               $time, port, got_data, got_fault, exp_data, exp_fault, line);
    end
  endtask

  initial begin
    load_expected();
  end

  always @(posedge clock) begin
    if (!reset && fetch_rsp_valid && fetch_rsp_ready) begin
      if (fetch_case.size() == 0) begin
        other_count++;
        $display("Fetch response at %0t arrived with no case left to match", $time);
      end else begin
        compare("fetch", fetch_exp_data.pop_front(), fetch_exp_fault.pop_front(),
                fetch_case.pop_front(), fetch_insn, fetch_fault);
      end
    end
  end

  always @(posedge clock) begin
    if (!reset && data_rsp_valid && data_rsp_ready) begin
      if (data_case.size() == 0) begin
        other_count++;
        $display("Data response at %0t arrived with no case left to match", $time);
      end else begin
        compare("data", data_exp_data.pop_front(), data_exp_fault.pop_front(),
                data_case.pop_front(), data_rdata, data_fault);
      end
    end
  end

  // outputs seen here were set by a reset edge.
  always @(posedge clock) begin
    if (reset_q === 1'b1) begin
      if (fetch_rsp_valid !== 1'b0 || data_rsp_valid !== 1'b0 ||
          fetch_ready !== 1'b1 || data_ready !== 1'b1) begin
        mismatch_count++;
        $display("Mismatch at %0t: reset state ready %b/%b rsp_valid %b/%b",
                 $time, fetch_ready, data_ready, fetch_rsp_valid, data_rsp_valid);
      end
    end
    reset_q <= reset;
  end

endmodule

//--- mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_subsystem_tb;
  import mem_pkg::*;

  localparam int wait_limit = 200;

  logic         clock;
  logic         reset;
  logic         fetch_valid;
  logic         fetch_ready;
  logic [31:0]  fetch_pc;
  logic         fetch_rsp_valid;
  logic         fetch_rsp_ready;
  logic [31:0]  fetch_insn;
  logic         fetch_fault;
  logic         data_valid;
  logic         data_ready;
  logic [31:0]  data_addr;
  access_size_e data_size;
  logic         data_sext;
  logic         data_write;
  logic [31:0]  data_wdata;
  logic         data_rsp_valid;
  logic         data_rsp_ready;
  logic [31:0]  data_rdata;
  logic         data_fault;

  logic         case_write [$];
  logic [31:0]  case_addr [$];
  int           case_size [$];
  logic         case_sext [$];
  logic [31:0]  case_wdata [$];
  int           data_list [$];
  int           fetch_list [$];
  int           fetch_after [$];  // data cases ahead of each fetch.
  int           data_done;
  int           driver_errors;
  int           leftover;
  int           seed;

  mem_subsystem dut0 (.*);

  mem_checker chk0 (.*);

  always #5 clock = ~clock;

  task automatic load_cases();
    int          fd;
    int          n;
    int          out_of_range;
    string       line;
    string       port_s;
    string       op_s;
    logic [31:0] addr;
    int          size;
    int          sext;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    int          exp_fault;
    n = 0;
    out_of_range = 0;
    fd = $fopen("mem_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open mem_cases.txt");
      driver_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%s %s %h %d %d %h %h %d", port_s, op_s, addr, size, sext,
                  wdata, exp_data, exp_fault) == 8) begin
        case_write.push_back(op_s == "w");
        case_addr.push_back(addr);
        case_size.push_back(size);
        case_sext.push_back(sext != 0);
        case_wdata.push_back(wdata);
        if (addr >= `MEM_BYTES) begin
          out_of_range++;
        end
        if (port_s == "f") begin
          fetch_list.push_back(n);
          fetch_after.push_back(data_list.size());
        end else begin
          data_list.push_back(n);
        end
        n++;
      end
    end
    $fclose(fd);
    $display("loaded %0d cases, %0d out of range", n, out_of_range);
    if (n == 0) begin
      $display("The case file holds no cases");
      driver_errors++;
    end
    if (out_of_range == 0) begin
      $display("The case file holds no access at or above the memory size");
      driver_errors++;
    end
  endtask

  task automatic send_data(input int i);
    int   n;
    logic got;
    repeat (($urandom % 4) + 1) @(posedge clock);  // idle gap.
    #1;
    data_valid = 1'b1;
    data_addr  = case_addr[i];
    data_size  = access_size_e'(case_size[i]);
    data_sext  = case_sext[i];
    data_write = case_write[i];
    data_wdata = case_wdata[i];
    got = 1'b0;
    for (n = 0; n < wait_limit && !got; n++) begin
      @(posedge clock);
      got = data_ready;
    end
    #1 data_valid = 1'b0;
    if (!got) begin
      $display("Data port stalled: request to %h was never accepted", case_addr[i]);
      driver_errors++;
      return;
    end
    got = 1'b0;
    for (n = 0; n < wait_limit && !got; n++) begin
      data_rsp_ready = ($urandom % 4) != 0;  // random back-pressure.
      @(posedge clock);
      got = data_rsp_valid & data_rsp_ready;
      #1;
    end
    data_rsp_ready = 1'b0;
    if (!got) begin
      $display("Data port stalled: no response for access to %h", case_addr[i]);
      driver_errors++;
    end
  endtask

  task automatic send_fetch(input int i);
    int   n;
    logic got;
    repeat (($urandom % 4) + 1) @(posedge clock);
    #1;
    fetch_valid = 1'b1;
    fetch_pc    = case_addr[i];
    got = 1'b0;
    for (n = 0; n < wait_limit && !got; n++) begin
      @(posedge clock);
      got = fetch_ready;
    end
    #1 fetch_valid = 1'b0;
    if (!got) begin
      $display("Fetch port stalled: pc %h was never accepted", case_addr[i]);
      driver_errors++;
      return;
    end
    got = 1'b0;
    for (n = 0; n < wait_limit && !got; n++) begin
      fetch_rsp_ready = ($urandom % 4) != 0;
      @(posedge clock);
      got = fetch_rsp_valid & fetch_rsp_ready;
      #1;
    end
    fetch_rsp_ready = 1'b0;
    if (!got) begin
      $display("Fetch port stalled: no response for pc %h", case_addr[i]);
      driver_errors++;
    end
  endtask

  // stall means no data case finished for wait_limit cycles.
  task automatic wait_for_data(input int needed);
    int n;
    int seen;
    n = 0;
    seen = data_done;
    while (data_done < needed && n < wait_limit && driver_errors == 0) begin
      @(posedge clock);
      if (data_done != seen) begin
        seen = data_done;
        n = 0;
      end else begin
        n++;
      end
    end
    if (data_done < needed && driver_errors == 0) begin
      $display("Fetch port stalled waiting for %0d earlier data cases", needed);
      driver_errors++;
    end
  endtask

  task automatic run_data_cases();
    int k;
    for (k = 0; k < data_list.size() && driver_errors == 0; k++) begin
      send_data(data_list[k]);
      data_done++;
    end
  endtask

  task automatic run_fetch_cases();
    int k;
    for (k = 0; k < fetch_list.size() && driver_errors == 0; k++) begin
      wait_for_data(fetch_after[k]);
      if (driver_errors == 0) begin
        send_fetch(fetch_list[k]);
      end
    end
  endtask

  initial begin
    seed = 15;
    void'($urandom(seed));
    clock           = 1'b0;
    reset           = 1'b1;
    fetch_valid     = 1'b0;
    fetch_pc        = '0;
    fetch_rsp_ready = 1'b0;
    data_valid      = 1'b0;
    data_addr       = '0;
    data_size       = size_word;
    data_sext       = 1'b0;
    data_write      = 1'b0;
    data_wdata      = '0;
    data_rsp_ready  = 1'b0;
    data_done       = 0;
    driver_errors   = 0;
    load_cases();
    repeat (16) @(posedge clock);
    #1 reset = 1'b0;
    fork
      run_data_cases();
      run_fetch_cases();
    join
    @(posedge clock);
    leftover = chk0.count_leftovers();
    $display("errors: %0d mismatches, %0d other checker errors, %0d driver errors",
             chk0.mismatch_count, chk0.other_count + leftover, driver_errors);
    if (chk0.mismatch_count + chk0.other_count + leftover + driver_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- mem_cases.txt
# port op addr size sext wdata exp_data exp_fault
# port d or f, op r or w, size 0 byte 1 half 2 word, addr and data in hex
d w 00000100 2 0 deadbeef 00000000 0
d r 00000100 2 0 00000000 deadbeef 0
f r 00000100 2 0 00000000 deadbeef 0
f r 00000102 2 0 00000000 deadbeef 0
f r 00000300 2 0 00000000 00000000 0
d w 00000200 0 0 000000a1 00000000 0
d w 00000201 0 0 000000b2 00000000 0
d w 00000202 0 0 000000c3 00000000 0
d w 00000203 0 0 000000f4 00000000 0
d r 00000200 2 0 00000000 f4c3b2a1 0
d w 00000204 1 0 00001234 00000000 0
d w 00000206 1 0 0000abcd 00000000 0
d r 00000204 2 0 00000000 abcd1234 0
d w 00000201 0 0 ffffff55 00000000 0
d r 00000200 2 0 00000000 f4c355a1 0
f r 00000200 2 0 00000000 f4c355a1 0
d r 00000200 0 1 00000000 ffffffa1 0
d r 00000200 0 0 00000000 000000a1 0
d r 00000201 0 1 00000000 00000055 0
f r 00000204 2 0 00000000 abcd1234 0
d r 00000202 0 1 00000000 ffffffc3 0
d r 00000203 0 0 00000000 000000f4 0
d r 00000203 0 1 00000000 fffffff4 0
d r 00000204 1 1 00000000 00001234 0
d r 00000206 1 1 00000000 ffffabcd 0
d r 00000206 1 0 00000000 0000abcd 0
d r 00000202 1 1 00000000 fffff4c3 0
d r 00000204 2 1 00000000 abcd1234 0
d w 00000400 2 0 11111111 00000000 1
d r 00000400 2 0 00000000 00000000 1
f r 00000400 2 0 00000000 00000000 1
d r 00000000 2 0 00000000 00000000 0
d w fffffffc 0 0 000000ee 00000000 1
d r 000003fc 2 0 00000000 00000000 0
f r 00000100 2 0 00000000 deadbeef 0
d r 00000200 2 0 00000000 f4c355a1 0

//--- mem_subsystem.f
+incdir+.
mem_pkg.sv
bus_if.sv
fetch_unit.sv
data_access_unit.sv
bus_arbiter.sv
sram_slave.sv
mem_subsystem.sv
mem_checker.sv
mem_subsystem_tb.sv
